//--- common/hci_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types and register map for the host controller interface
// Byte addresses only, register words are always 32 bits wide
//////////////////////////////////////////////////////////////////////

package hci_pkg;

  typedef logic [31:0] data_t;       // One register word
  typedef logic [7:0]  addr_t;       // Register bus byte address
  typedef logic [1:0]  axi_resp_t;   // AXI response code
  typedef logic [7:0]  thld_t;       // Queue threshold
  typedef logic [7:0]  level_t;      // Queue occupancy, depth up to 128

  // Command descriptor
  //   31:16 data length, 15:8 command code, 7:4 tid, 3:0 attribute
  typedef logic [31:0] cmd_desc_t;

  // Response descriptor
  //   31:28 error status, 27:24 tid, 15:0 data length, rest zero
  typedef logic [31:0] resp_desc_t;

  localparam axi_resp_t AXI_OKAY   = 2'b00;
  localparam axi_resp_t AXI_SLVERR = 2'b10;

  // Register offsets
  localparam addr_t ADDR_CMD_PORT   = 8'h00;  // Write only
  localparam addr_t ADDR_RESP_PORT  = 8'h04;  // Read only
  localparam addr_t ADDR_THLD_CTRL  = 8'h08;  // {resp_thld, cmd_thld}
  localparam addr_t ADDR_QUEUE_STAT = 8'h0C;  // Read only
  localparam addr_t ADDR_RESET_CTRL = 8'h10;  // Self clearing

  // Response error status
  localparam logic [3:0] ERR_SUCCESS  = 4'h0;
  localparam logic [3:0] ERR_BAD_ATTR = 4'h1;

endpackage : hci_pkg

//--- logic/hci_fifo.sv
//////////////////////////////////////////////////////////////////////
// Show-ahead FIFO, rdata_o valid whenever not empty
// Flush beats push and pop in the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hci_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  logic [WIDTH-1:0]           wdata_i,
  input  logic                       pop_i,
  output logic [WIDTH-1:0]           rdata_o,
  output logic                       full_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] level_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (level_o == LVL_W'(DEPTH));
  assign empty_o = (level_o == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign rdata_o = mem[rd_ptr];

  // Wrap explicitly so depths that are not a power of two work
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_o <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   level_o <= level_o + 1'b1;
        2'b01:   level_o <= level_o - 1'b1;
        default: level_o <= level_o;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) mem[wr_ptr] <= wdata_i;
  end

endmodule : hci_fifo

//--- csr/hci_csr.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite register front end, one outstanding read and one write
// WSTRB is ignored, every write updates the whole word
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hci_csr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // AXI4-Lite slave
  input  hci_pkg::addr_t     awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  hci_pkg::data_t     wdata_i,
  input  logic [3:0]         wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output hci_pkg::axi_resp_t bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,
  input  hci_pkg::addr_t     araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output hci_pkg::data_t     rdata_o,
  output hci_pkg::axi_resp_t rresp_o,
  output logic               rvalid_o,
  input  logic               rready_i,
  // Queue side
  output logic               cmd_push_o,
  output hci_pkg::cmd_desc_t cmd_data_o,
  input  logic               cmd_full_i,
  input  hci_pkg::level_t    cmd_level_i,
  output logic               resp_pop_o,
  input  hci_pkg::resp_desc_t resp_data_i,
  input  logic               resp_empty_i,
  input  hci_pkg::level_t    resp_level_i,
  output hci_pkg::thld_t     cmd_thld_o,
  output hci_pkg::thld_t     resp_thld_o,
  input  logic               cmd_below_thld_i,
  input  logic               resp_above_thld_i,
  output logic               cmd_rst_req_o,
  output logic               resp_rst_req_o,
  input  logic               cmd_rst_done_i,
  input  logic               resp_rst_done_i
);

  logic               wr_acc;
  logic               rd_acc;
  logic               rst_wr;
  hci_pkg::axi_resp_t wr_resp;
  hci_pkg::axi_resp_t rd_resp;
  hci_pkg::data_t     rd_data;

  // Accept only when the previous response has been taken
  assign wr_acc    = awvalid_i & wvalid_i & ~bvalid_o;
  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign rd_acc    = arvalid_i & ~rvalid_o;
  assign arready_o = rd_acc;

  assign cmd_push_o = wr_acc && (awaddr_i == hci_pkg::ADDR_CMD_PORT);
  assign cmd_data_o = wdata_i;  // Strobes in wstrb_i not used
  assign resp_pop_o = rd_acc && (araddr_i == hci_pkg::ADDR_RESP_PORT);
  assign rst_wr     = wr_acc && (awaddr_i == hci_pkg::ADDR_RESET_CTRL);

  always_comb begin
    case (awaddr_i)
      hci_pkg::ADDR_CMD_PORT:   wr_resp = cmd_full_i ? hci_pkg::AXI_SLVERR : hci_pkg::AXI_OKAY;
      hci_pkg::ADDR_THLD_CTRL,
      hci_pkg::ADDR_RESET_CTRL: wr_resp = hci_pkg::AXI_OKAY;
      default:                  wr_resp = hci_pkg::AXI_SLVERR;  // Unmapped or read only
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = hci_pkg::AXI_OKAY;
    case (araddr_i)
      hci_pkg::ADDR_RESP_PORT: begin
        if (resp_empty_i) rd_resp = hci_pkg::AXI_SLVERR;
        else rd_data = resp_data_i;
      end
      hci_pkg::ADDR_THLD_CTRL:  rd_data = {16'h0, resp_thld_o, cmd_thld_o};
      hci_pkg::ADDR_QUEUE_STAT: begin
        rd_data = {12'h0, resp_above_thld_i, cmd_below_thld_i, resp_empty_i,
                   (cmd_level_i == '0), resp_level_i, cmd_level_i};
      end
      hci_pkg::ADDR_RESET_CTRL: rd_data = {30'h0, resp_rst_req_o, cmd_rst_req_o};
      default:                  rd_resp = hci_pkg::AXI_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_o <= 1'b0;
      bresp_o  <= hci_pkg::AXI_OKAY;
      rvalid_o <= 1'b0;
      rresp_o  <= hci_pkg::AXI_OKAY;
    end else begin
      if (wr_acc) begin
        bvalid_o <= 1'b1;
        bresp_o  <= wr_resp;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_acc) begin
        rvalid_o <= 1'b1;
        rresp_o  <= rd_resp;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // Read data held until RREADY
  always_ff @(posedge clk_i) begin
    if (rd_acc) rdata_o <= rd_data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_thld_o     <= 8'd1;
      resp_thld_o    <= 8'd1;
      cmd_rst_req_o  <= 1'b0;
      resp_rst_req_o <= 1'b0;
    end else begin
      if (wr_acc && (awaddr_i == hci_pkg::ADDR_THLD_CTRL)) begin
        cmd_thld_o  <= wdata_i[7:0];
        resp_thld_o <= wdata_i[15:8];
      end
      // Request stays up until the queue reports the flush
      if (rst_wr && wdata_i[0]) cmd_rst_req_o <= 1'b1;
      else if (cmd_rst_done_i) cmd_rst_req_o <= 1'b0;
      if (rst_wr && wdata_i[1]) resp_rst_req_o <= 1'b1;
      else if (resp_rst_done_i) resp_rst_req_o <= 1'b0;
    end
  end

endmodule : hci_csr

//--- queues/hci_queues.sv
//////////////////////////////////////////////////////////////////////
// Command and response queues with threshold flags and soft reset
// Depths up to 128, flags lag the level by one cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hci_queues #(
  parameter int CMD_DEPTH  = 8,
  parameter int RESP_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Register block side
  input  logic                cmd_push_i,
  input  hci_pkg::cmd_desc_t  cmd_data_i,
  output logic                cmd_full_o,
  output hci_pkg::level_t     cmd_level_o,
  input  logic                resp_pop_i,
  output hci_pkg::resp_desc_t resp_data_o,
  output logic                resp_empty_o,
  output hci_pkg::level_t     resp_level_o,
  input  hci_pkg::thld_t      cmd_thld_i,
  input  hci_pkg::thld_t      resp_thld_i,
  input  logic                cmd_rst_req_i,
  input  logic                resp_rst_req_i,
  output logic                cmd_rst_done_o,
  output logic                resp_rst_done_o,
  // Engine side
  output logic                cmd_rvalid_o,
  input  logic                cmd_rready_i,
  output hci_pkg::cmd_desc_t  cmd_rdata_o,
  input  logic                resp_wvalid_i,
  output logic                resp_wready_o,
  input  hci_pkg::resp_desc_t resp_wdata_i,
  // Threshold flags
  output logic                cmd_below_thld_o,
  output logic                resp_above_thld_o
);

  logic                            cmd_empty;
  logic                            resp_full;
  logic [$clog2(CMD_DEPTH+1)-1:0]  cmd_lvl;
  logic [$clog2(RESP_DEPTH+1)-1:0] resp_lvl;
  hci_pkg::thld_t                  cmd_thld_eff;
  hci_pkg::thld_t                  resp_thld_eff;

  // Flush takes one cycle, so the request itself is the done pulse
  assign cmd_rst_done_o  = cmd_rst_req_i;
  assign resp_rst_done_o = resp_rst_req_i;

  // Hold the engine off during a flush so nothing is lost or popped
  assign cmd_rvalid_o  = ~cmd_empty & ~cmd_rst_req_i;
  assign resp_wready_o = ~resp_full & ~resp_rst_req_i;

  assign cmd_level_o  = hci_pkg::level_t'(cmd_lvl);
  assign resp_level_o = hci_pkg::level_t'(resp_lvl);

  // Zero threshold behaves as one
  assign cmd_thld_eff  = (cmd_thld_i == '0) ? 8'd1 : cmd_thld_i;
  assign resp_thld_eff = (resp_thld_i == '0) ? 8'd1 : resp_thld_i;

  hci_fifo #(.DEPTH(CMD_DEPTH), .WIDTH(32)) u_cmd_fifo (
    .clk_i,
    .rst_n_i,
    .flush_i (cmd_rst_req_i),
    .push_i  (cmd_push_i),
    .wdata_i (cmd_data_i),
    .pop_i   (cmd_rvalid_o & cmd_rready_i),
    .rdata_o (cmd_rdata_o),
    .full_o  (cmd_full_o),
    .empty_o (cmd_empty),
    .level_o (cmd_lvl)
  );

  hci_fifo #(.DEPTH(RESP_DEPTH), .WIDTH(32)) u_resp_fifo (
    .clk_i,
    .rst_n_i,
    .flush_i (resp_rst_req_i),
    .push_i  (resp_wvalid_i & resp_wready_o),
    .wdata_i (resp_wdata_i),
    .pop_i   (resp_pop_i),
    .rdata_o (resp_data_o),
    .full_o  (resp_full),
    .empty_o (resp_empty_o),
    .level_o (resp_lvl)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_below_thld_o  <= 1'b0;
      resp_above_thld_o <= 1'b0;
    end else begin
      cmd_below_thld_o  <= (cmd_level_o < cmd_thld_eff);
      resp_above_thld_o <= (resp_level_o >= resp_thld_eff);
    end
  end

endmodule : hci_queues

//--- logic/cmd_engine.sv
//////////////////////////////////////////////////////////////////////
// Stand-in for the bus controller, one response per command
// Only attributes 0 and 1 are accepted, command code is not decoded
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cmd_engine (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                exec_en_i,
  input  logic                cmd_rvalid_i,
  output logic                cmd_rready_o,
  input  hci_pkg::cmd_desc_t  cmd_rdata_i,
  output logic                resp_wvalid_o,
  input  logic                resp_wready_i,
  output hci_pkg::resp_desc_t resp_wdata_o
);

  typedef enum logic {
    IDLE,
    RESPOND
  } state_t;

  state_t     state_q;
  logic       cmd_pop;
  logic [3:0] status;

  assign cmd_rready_o  = (state_q == IDLE) && exec_en_i;
  assign cmd_pop       = cmd_rready_o & cmd_rvalid_i;
  assign resp_wvalid_o = (state_q == RESPOND);

  // Attribute check
  assign status = (cmd_rdata_i[3:0] <= 4'd1) ? hci_pkg::ERR_SUCCESS : hci_pkg::ERR_BAD_ATTR;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (cmd_pop) state_q <= RESPOND;
        RESPOND: if (resp_wready_i) state_q <= IDLE;  // Stall while queue full
        default: state_q <= IDLE;
      endcase
    end
  end

  // Response built once at pop and held through back-pressure
  always_ff @(posedge clk_i) begin
    if (cmd_pop) begin
      resp_wdata_o <= {status, cmd_rdata_i[7:4], 8'h00, cmd_rdata_i[31:16]};
    end
  end

endmodule : cmd_engine

//--- logic/hci_top.sv
//////////////////////////////////////////////////////////////////////
// Host controller top, register block feeding queues and engine
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hci_top #(
  parameter int CMD_DEPTH  = 8,
  parameter int RESP_DEPTH = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hci_pkg::addr_t     awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  hci_pkg::data_t     wdata_i,
  input  logic [3:0]         wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  output hci_pkg::axi_resp_t bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,
  input  hci_pkg::addr_t     araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  output hci_pkg::data_t     rdata_o,
  output hci_pkg::axi_resp_t rresp_o,
  output logic               rvalid_o,
  input  logic               rready_i,
  input  logic               exec_en_i,
  output logic               cmd_below_thld_o,
  output logic               resp_above_thld_o
);

  logic                cmd_push;
  hci_pkg::cmd_desc_t  cmd_data;
  logic                cmd_full;
  hci_pkg::level_t     cmd_level;
  logic                resp_pop;
  hci_pkg::resp_desc_t resp_data;
  logic                resp_empty;
  hci_pkg::level_t     resp_level;
  hci_pkg::thld_t      cmd_thld;
  hci_pkg::thld_t      resp_thld;
  logic                cmd_rst_req;
  logic                resp_rst_req;
  logic                cmd_rst_done;
  logic                resp_rst_done;
  logic                cmd_rvalid;
  logic                cmd_rready;
  hci_pkg::cmd_desc_t  cmd_rdata;
  logic                resp_wvalid;
  logic                resp_wready;
  hci_pkg::resp_desc_t resp_wdata;

  hci_csr u_csr (
    .clk_i, .rst_n_i,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .cmd_push_o        (cmd_push),
    .cmd_data_o        (cmd_data),
    .cmd_full_i        (cmd_full),
    .cmd_level_i       (cmd_level),
    .resp_pop_o        (resp_pop),
    .resp_data_i       (resp_data),
    .resp_empty_i      (resp_empty),
    .resp_level_i      (resp_level),
    .cmd_thld_o        (cmd_thld),
    .resp_thld_o       (resp_thld),
    .cmd_below_thld_i  (cmd_below_thld_o),
    .resp_above_thld_i (resp_above_thld_o),
    .cmd_rst_req_o     (cmd_rst_req),
    .resp_rst_req_o    (resp_rst_req),
    .cmd_rst_done_i    (cmd_rst_done),
    .resp_rst_done_i   (resp_rst_done)
  );

  hci_queues #(
    .CMD_DEPTH  (CMD_DEPTH),
    .RESP_DEPTH (RESP_DEPTH)
  ) u_queues (
    .clk_i, .rst_n_i,
    .cmd_push_i      (cmd_push),
    .cmd_data_i      (cmd_data),
    .cmd_full_o      (cmd_full),
    .cmd_level_o     (cmd_level),
    .resp_pop_i      (resp_pop),
    .resp_data_o     (resp_data),
    .resp_empty_o    (resp_empty),
    .resp_level_o    (resp_level),
    .cmd_thld_i      (cmd_thld),
    .resp_thld_i     (resp_thld),
    .cmd_rst_req_i   (cmd_rst_req),
    .resp_rst_req_i  (resp_rst_req),
    .cmd_rst_done_o  (cmd_rst_done),
    .resp_rst_done_o (resp_rst_done),
    .cmd_rvalid_o    (cmd_rvalid),
    .cmd_rready_i    (cmd_rready),
    .cmd_rdata_o     (cmd_rdata),
    .resp_wvalid_i   (resp_wvalid),
    .resp_wready_o   (resp_wready),
    .resp_wdata_i    (resp_wdata),
    .cmd_below_thld_o,
    .resp_above_thld_o
  );

  cmd_engine u_engine (
    .clk_i, .rst_n_i,
    .exec_en_i,
    .cmd_rvalid_i  (cmd_rvalid),
    .cmd_rready_o  (cmd_rready),
    .cmd_rdata_i   (cmd_rdata),
    .resp_wvalid_o (resp_wvalid),
    .resp_wready_i (resp_wready),
    .resp_wdata_o  (resp_wdata)
  );

endmodule : hci_top

//--- sim/tb_hci_tasks.svh
//////////////////////////////////////////////////////////////////////
// Bus driver and compare tasks, included inside tb_hci only
// Uses the testbench clock, bus signals and error counters in scope
//////////////////////////////////////////////////////////////////////
`ifndef TB_HCI_TASKS_SVH
`define TB_HCI_TASKS_SVH

// Random wait of 0 to 3 cycles before BREADY or RREADY
task automatic ready_delay();
  int unsigned cycles;
  cycles = $urandom % 4;
  repeat (cycles) @(posedge clk);
endtask

task automatic write_reg(input hci_pkg::addr_t addr, input hci_pkg::data_t data,
                         output hci_pkg::axi_resp_t resp);
  @(posedge clk);
  awaddr  <= addr;
  wdata   <= data;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  @(negedge clk);
  while (!awready) @(negedge clk);
  check_flag("wready_o", wready, 1'b1);  // Pulses with AWREADY
  @(posedge clk);  // Accept edge
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  @(negedge clk);
  while (!bvalid) @(negedge clk);
  resp = bresp;
  ready_delay();
  @(posedge clk);
  bready <= 1'b1;
  @(posedge clk);
  bready <= 1'b0;
endtask

task automatic read_reg(input hci_pkg::addr_t addr, output hci_pkg::data_t data,
                        output hci_pkg::axi_resp_t resp);
  @(posedge clk);
  araddr  <= addr;
  arvalid <= 1'b1;
  @(negedge clk);
  while (!arready) @(negedge clk);
  @(posedge clk);
  arvalid <= 1'b0;
  @(negedge clk);
  while (!rvalid) @(negedge clk);
  data = rdata;
  resp = rresp;
  ready_delay();
  @(posedge clk);
  rready <= 1'b1;
  @(posedge clk);
  rready <= 1'b0;
endtask

task automatic check_data(input string name, input hci_pkg::data_t got,
                          input hci_pkg::data_t exp);
  if (got !== exp) begin
    err_data++;
    $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
  end
endtask

task automatic check_resp(input string name, input hci_pkg::axi_resp_t got,
                          input hci_pkg::axi_resp_t exp);
  if (got !== exp) begin
    err_resp++;
    $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    err_flag++;
    $display("[ERROR] row %0d %s: got 0x%h, expected 0x%h", cur_row, name, got, exp);
  end
endtask

`endif

//--- sim/tb_hci.sv
//////////////////////////////////////////////////////////////////////
// Table driven testbench for hci_top with depth 4 queues
// Expected values come from a queue and engine model built with the table
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_hci;

  localparam int DEPTH    = 4;
  localparam int MAX_ROWS = 128;

  typedef enum int {OP_WRITE, OP_READ, OP_EXEC, OP_WAIT} op_e;

  logic               clk = 1'b0;
  logic               rst_n;
  hci_pkg::addr_t     awaddr;
  logic               awvalid;
  logic               awready;
  hci_pkg::data_t     wdata;
  logic [3:0]         wstrb;
  logic               wvalid;
  logic               wready;
  hci_pkg::axi_resp_t bresp;
  logic               bvalid;
  logic               bready;
  hci_pkg::addr_t     araddr;
  logic               arvalid;
  logic               arready;
  hci_pkg::data_t     rdata;
  hci_pkg::axi_resp_t rresp;
  logic               rvalid;
  logic               rready;
  logic               exec_en;
  logic               cmd_below_thld;
  logic               resp_above_thld;

  int          err_data   = 0;
  int          err_resp   = 0;
  int          err_flag   = 0;
  int          err_other  = 0;
  int          cur_row    = 0;
  int          n_rows     = 0;
  logic        table_ready = 1'b0;

  // Stimulus table, one entry per row
  op_e                row_op        [MAX_ROWS];
  hci_pkg::addr_t     row_addr      [MAX_ROWS];
  hci_pkg::data_t     row_data      [MAX_ROWS];
  hci_pkg::data_t     row_exp_data  [MAX_ROWS];
  hci_pkg::axi_resp_t row_exp_resp  [MAX_ROWS];
  logic               row_chk_flags [MAX_ROWS];
  logic               row_exp_below [MAX_ROWS];
  logic               row_exp_above [MAX_ROWS];

  // Reference model state
  hci_pkg::cmd_desc_t  exp_cmd_q[$];
  hci_pkg::resp_desc_t exp_resp_q[$];
  hci_pkg::resp_desc_t eng_resp;
  logic                eng_busy      = 1'b0;  // Engine holds a response
  logic                exp_exec      = 1'b0;
  hci_pkg::thld_t      exp_cmd_thld  = 8'd1;
  hci_pkg::thld_t      exp_resp_thld = 8'd1;

  `include "tb_hci_tasks.svh"

  always #4 clk = ~clk;

  hci_top #(.CMD_DEPTH(DEPTH), .RESP_DEPTH(DEPTH)) DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .exec_en_i (exec_en),
    .cmd_below_thld_o (cmd_below_thld),
    .resp_above_thld_o (resp_above_thld)
  );

  // Status 0 for attribute 0 or 1, tid and length copied
  function automatic hci_pkg::resp_desc_t response_for(input hci_pkg::cmd_desc_t cmd);
    hci_pkg::resp_desc_t resp;
    resp        = '0;
    resp[31:28] = (cmd[3:0] inside {4'd0, 4'd1}) ? hci_pkg::ERR_SUCCESS
                                                 : hci_pkg::ERR_BAD_ATTR;
    resp[27:24] = cmd[7:4];
    resp[15:0]  = cmd[31:16];
    return resp;
  endfunction

  function automatic hci_pkg::cmd_desc_t make_cmd(input int i);
    return {16'(i * 3 + 1), 8'(8'h40 + i), 4'(i), 4'(i % 4)};
  endfunction

  // Runs the engine until nothing more can move
  function automatic void advance_engine();
    logic moved;
    moved = 1'b1;
    while (moved) begin
      moved = 1'b0;
      if (eng_busy && (exp_resp_q.size() < DEPTH)) begin
        exp_resp_q.push_back(eng_resp);
        eng_busy = 1'b0;
        moved    = 1'b1;
      end else if (!eng_busy && exp_exec && (exp_cmd_q.size() > 0)) begin
        eng_resp = response_for(exp_cmd_q.pop_front());
        eng_busy = 1'b1;
        moved    = 1'b1;
      end
    end
  endfunction

  function automatic logic [1:0] threshold_flags();  // {above, below}
    int cmd_eff;
    int resp_eff;
    cmd_eff  = (exp_cmd_thld == '0) ? 1 : int'(exp_cmd_thld);
    resp_eff = (exp_resp_thld == '0) ? 1 : int'(exp_resp_thld);
    return {exp_resp_q.size() >= resp_eff, exp_cmd_q.size() < cmd_eff};
  endfunction

  function automatic hci_pkg::data_t queue_status();
    logic [1:0] flags;
    flags = threshold_flags();
    return {12'h0, flags, exp_resp_q.size() == 0, exp_cmd_q.size() == 0,
            8'(exp_resp_q.size()), 8'(exp_cmd_q.size())};
  endfunction

  function automatic void add_row(input op_e op, input hci_pkg::addr_t addr,
                                  input hci_pkg::data_t data);
    hci_pkg::data_t     exp_d;
    hci_pkg::axi_resp_t exp_r;
    logic [1:0]         flags;
    exp_d = '0;
    exp_r = hci_pkg::AXI_OKAY;
    case (op)
      OP_WRITE: begin
        if (addr == hci_pkg::ADDR_CMD_PORT) begin
          if (exp_cmd_q.size() < DEPTH) exp_cmd_q.push_back(data);
          else exp_r = hci_pkg::AXI_SLVERR;  // Word dropped
        end else if (addr == hci_pkg::ADDR_THLD_CTRL) begin
          exp_cmd_thld  = data[7:0];
          exp_resp_thld = data[15:8];
        end else if (addr == hci_pkg::ADDR_RESET_CTRL) begin
          if (data[0]) exp_cmd_q.delete();
          if (data[1]) exp_resp_q.delete();
        end else begin
          exp_r = hci_pkg::AXI_SLVERR;
        end
      end
      OP_READ: begin
        if (addr == hci_pkg::ADDR_RESP_PORT) begin
          if (exp_resp_q.size() == 0) exp_r = hci_pkg::AXI_SLVERR;
          else exp_d = exp_resp_q.pop_front();
        end else if (addr == hci_pkg::ADDR_THLD_CTRL) begin
          exp_d = {16'h0, exp_resp_thld, exp_cmd_thld};
        end else if (addr == hci_pkg::ADDR_QUEUE_STAT) begin
          exp_d = queue_status();
        end else if (addr != hci_pkg::ADDR_RESET_CTRL) begin
          exp_r = hci_pkg::AXI_SLVERR;  // Reset bits read 0 once done
        end
      end
      OP_EXEC: exp_exec = data[0];
      default: ;
    endcase
    advance_engine();
    if (op == OP_WAIT) exp_d = queue_status();
    flags = threshold_flags();
    row_op[n_rows]        = op;
    row_addr[n_rows]      = addr;
    row_data[n_rows]      = data;
    row_exp_data[n_rows]  = exp_d;
    row_exp_resp[n_rows]  = exp_r;
    row_chk_flags[n_rows] = (op == OP_WAIT) || ((op != OP_EXEC) && !exp_exec);
    row_exp_below[n_rows] = flags[0];
    row_exp_above[n_rows] = flags[1];
    n_rows++;
  endfunction

  // With the engine running every access is followed by a settle row
  function automatic void step(input op_e op, input hci_pkg::addr_t addr,
                               input hci_pkg::data_t data);
    add_row(op, addr, data);
    if (exp_exec) add_row(OP_WAIT, '0, '0);
  endfunction

  function automatic void build_table();
    int i;
    step(OP_WRITE, hci_pkg::ADDR_THLD_CTRL, 32'h0000_0302);
    step(OP_READ, hci_pkg::ADDR_THLD_CTRL, '0);
    step(OP_READ, 8'h14, '0);
    step(OP_WRITE, hci_pkg::ADDR_QUEUE_STAT, 32'h1);
    step(OP_WRITE, 8'h20, 32'h1);
    step(OP_READ, hci_pkg::ADDR_CMD_PORT, '0);
    // Engine off, overfill the command queue
    step(OP_READ, hci_pkg::ADDR_RESP_PORT, '0);
    for (i = 0; i < 5; i++) step(OP_WRITE, hci_pkg::ADDR_CMD_PORT, make_cmd(i));
    step(OP_READ, hci_pkg::ADDR_QUEUE_STAT, '0);
    // Soft reset of the command queue
    step(OP_WRITE, hci_pkg::ADDR_RESET_CTRL, 32'h1);
    step(OP_READ, hci_pkg::ADDR_QUEUE_STAT, '0);
    step(OP_READ, hci_pkg::ADDR_RESET_CTRL, '0);
    step(OP_EXEC, '0, 32'h1);
    step(OP_READ, hci_pkg::ADDR_RESP_PORT, '0);
    for (i = 5; i < 8; i++) step(OP_WRITE, hci_pkg::ADDR_CMD_PORT, make_cmd(i));
    for (i = 0; i < 3; i++) step(OP_READ, hci_pkg::ADDR_RESP_PORT, '0);
    // Back-pressure, response queue full and engine stalled
    for (i = 8; i < 18; i++) step(OP_WRITE, hci_pkg::ADDR_CMD_PORT, make_cmd(i));
    step(OP_READ, hci_pkg::ADDR_QUEUE_STAT, '0);
    for (i = 0; i < 10; i++) step(OP_READ, hci_pkg::ADDR_RESP_PORT, '0);
    step(OP_WRITE, hci_pkg::ADDR_THLD_CTRL, 32'h0);  // Zero acts as one
    step(OP_READ, hci_pkg::ADDR_QUEUE_STAT, '0);
  endfunction

  // Polls QUEUE_STAT until both levels match the model
  task automatic wait_idle(input logic [15:0] exp_lvl);
    hci_pkg::data_t     stat;
    hci_pkg::axi_resp_t resp;
    int                 polls;
    polls = 1;
    read_reg(hci_pkg::ADDR_QUEUE_STAT, stat, resp);
    while ((stat[15:0] !== exp_lvl) && (polls < 16)) begin
      read_reg(hci_pkg::ADDR_QUEUE_STAT, stat, resp);
      polls++;
    end
    if (stat[15:0] !== exp_lvl) begin
      err_other++;
      $display("Row %0d: queue levels never settled, last status 0x%h", cur_row, stat);
    end
  endtask

  task automatic apply_row(input int r);
    hci_pkg::data_t     rd;
    hci_pkg::axi_resp_t resp;
    case (row_op[r])
      OP_WRITE: begin
        write_reg(row_addr[r], row_data[r], resp);
        check_resp("bresp_o", resp, row_exp_resp[r]);
      end
      OP_READ: begin
        read_reg(row_addr[r], rd, resp);
        check_resp("rresp_o", resp, row_exp_resp[r]);
        check_data("rdata_o", rd, row_exp_data[r]);
      end
      OP_EXEC: begin
        @(posedge clk);
        exec_en <= row_data[r][0];
      end
      default: wait_idle(row_exp_data[r][15:0]);
    endcase
    if (row_chk_flags[r]) begin
      @(negedge clk);
      check_flag("cmd_below_thld_o", cmd_below_thld, row_exp_below[r]);
      check_flag("resp_above_thld_o", resp_above_thld, row_exp_above[r]);
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'h8791));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hF;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    exec_en = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (i = 0; i < n_rows; i++) begin
      cur_row = i;
      apply_row(i);
    end
    @(negedge clk);
    $display("Errors: data %0d, response %0d, flag %0d, other %0d",
             err_data, err_resp, err_flag, err_other);
    if ((err_data + err_resp + err_flag + err_other) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, 200 cycles per table row
  initial begin
    wait (table_ready);
    repeat (n_rows * 200) @(posedge clk);
    $display("Timeout: table did not finish within %0d cycles", n_rows * 200);
    $display("Test failed");
    $finish;
  end

endmodule : tb_hci

//--- filelist.f
+incdir+sim
common/hci_pkg.sv
logic/hci_fifo.sv
csr/hci_csr.sv
queues/hci_queues.sv
logic/cmd_engine.sv
logic/hci_top.sv
sim/tb_hci.sv

//--- run_sim.sh
#!/bin/sh
# Builds tb_hci with Verilator, runs it and checks sim.log for the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_hci -f filelist.f \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_hci > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log

cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation PASSED"
